// ==== source/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// machine-mode csr addresses
`define CSR_A_MSTATUS       `CSR_ADDR_W'h300
`define CSR_A_MIE           `CSR_ADDR_W'h304
`define CSR_A_MTVEC         `CSR_ADDR_W'h305
`define CSR_A_MSCRATCH      `CSR_ADDR_W'h340
`define CSR_A_MEPC          `CSR_ADDR_W'h341
`define CSR_A_MCAUSE        `CSR_ADDR_W'h342
`define CSR_A_MTVAL         `CSR_ADDR_W'h343
`define CSR_A_MCYCLE        `CSR_ADDR_W'hb00
`define CSR_A_MINSTRET      `CSR_ADDR_W'hb02
`define CSR_A_MVENDORID     `CSR_ADDR_W'hf11
`define CSR_A_MARCHID       `CSR_ADDR_W'hf12

// read-only id values
`define CSR_MVENDORID_VAL   `CSR_XLEN'h0000_0a5c
`define CSR_MARCHID_VAL     `CSR_XLEN'h0000_0017

// trap handling
`define CSR_MPP_MASK        `CSR_XLEN'h0000_1800
`define CSR_CAUSE_ECALL     `CSR_XLEN'd11

// request buffer depth, also the initial credits on both channels
`define CSR_CREDITS         2

`endif

// ==== source/csr_pkg.sv ====
`include "csr_consts.svh"

package csr_pkg;

    // i-type layout used by the zicsr instructions
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] csr_addr;
        logic [4:0]             rs1_uimm;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        logic [6:0]             opcode;
    } csr_fmt_t;

    // r-type layout, tells ecall from mret
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } priv_fmt_t;

    typedef union packed {
        csr_fmt_t  csr_view;
        priv_fmt_t priv_view;
    } sys_inst_u;

    typedef struct packed {
        sys_inst_u            inst;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] rs1_val;
    } sys_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] rd_val;
        logic [4:0]           rd;
        logic                 rd_we;
        logic                 redirect;
        logic [`CSR_XLEN-1:0] redirect_pc;
    } sys_rsp_t;

    typedef enum logic [2:0] {
        CSR_OP_NONE,
        CSR_OP_WRITE,
        CSR_OP_SET,
        CSR_OP_CLEAR,
        CSR_OP_ECALL,
        CSR_OP_MRET
    } csr_op_e;

    typedef struct packed {
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   wdata;
        logic [`CSR_XLEN-1:0]   pc;
    } csr_cmd_t;

endpackage

// ==== source/csr_req_fifo.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_req_fifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_push,
    input  csr_pkg::sys_req_t i_req,
    input  logic              i_pop,
    output logic              o_empty,
    output csr_pkg::sys_req_t o_head
);

    localparam int PTR_W = (`CSR_CREDITS > 1) ? $clog2(`CSR_CREDITS) : 1;
    localparam int CNT_W = $clog2(`CSR_CREDITS + 1);

    csr_pkg::sys_req_t mem [`CSR_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // storage, written at the write pointer
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CSR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CSR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy, push and pop may coincide
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];

endmodule

// ==== source/csr_seq_fsm.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_seq_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_empty,
    input  csr_pkg::sys_req_t    i_head,
    output logic                 o_pop,
    output logic                 o_req_credit,
    output csr_pkg::csr_cmd_t    o_cmd,
    output logic                 o_exec,
    input  logic [`CSR_XLEN-1:0] i_rdata,
    input  logic [`CSR_XLEN-1:0] i_mtvec,
    input  logic [`CSR_XLEN-1:0] i_mepc,
    output logic                 o_retire,
    input  logic                 i_rsp_credit,
    output logic                 o_rsp_valid,
    output csr_pkg::sys_rsp_t    o_rsp
);

    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;
    localparam logic [6:0] F7_MRET     = 7'b0011000;
    localparam logic [4:0] RS2_MRET    = 5'b00010;
    localparam int         CRED_W      = $clog2(`CSR_CREDITS + 1);

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_RESP} state_e;

    state_e             state;
    logic [CRED_W-1:0]  rsp_cred;
    csr_pkg::sys_inst_u inst;
    csr_pkg::csr_cmd_t  cmd_d;
    csr_pkg::csr_cmd_t  cmd_q;
    csr_pkg::sys_rsp_t  rsp_q;
    logic               is_sys;
    logic               is_csr;
    logic               is_ecall;
    logic               is_mret;

    assign inst = i_head.inst;

    // decode the head entry through both views of the word
    always_comb begin
        is_sys   = (inst.csr_view.opcode == OPC_SYSTEM);
        is_csr   = is_sys && (inst.csr_view.funct3[1:0] != 2'b00);
        is_ecall = is_sys && (inst.priv_view.funct3 == 3'b000)
                   && (inst.priv_view.funct7 == 7'd0) && (inst.priv_view.rs2 == 5'd0);
        is_mret  = is_sys && (inst.priv_view.funct3 == 3'b000)
                   && (inst.priv_view.funct7 == F7_MRET) && (inst.priv_view.rs2 == RS2_MRET);
        cmd_d.addr = inst.csr_view.csr_addr;
        cmd_d.pc   = i_head.pc;
        // immediate forms carry a zero-extended uimm
        cmd_d.wdata = inst.csr_view.funct3[2]
                      ? {{(`CSR_XLEN - 5){1'b0}}, inst.csr_view.rs1_uimm}
                      : i_head.rs1_val;
        cmd_d.op = csr_pkg::CSR_OP_NONE;
        if (is_ecall) begin
            cmd_d.op = csr_pkg::CSR_OP_ECALL;
        end else if (is_mret) begin
            cmd_d.op = csr_pkg::CSR_OP_MRET;
        end else if (is_csr) begin
            case (inst.csr_view.funct3[1:0])
                2'b01: cmd_d.op = csr_pkg::CSR_OP_WRITE;
                // set/clear with x0 or zero uimm is a pure read
                2'b10: cmd_d.op = (inst.csr_view.rs1_uimm != 5'd0) ? csr_pkg::CSR_OP_SET
                                                                    : csr_pkg::CSR_OP_NONE;
                default: cmd_d.op = (inst.csr_view.rs1_uimm != 5'd0) ? csr_pkg::CSR_OP_CLEAR
                                                                      : csr_pkg::CSR_OP_NONE;
            endcase
        end
    end

    assign o_pop        = (state == S_IDLE) && !i_empty;
    assign o_req_credit = o_pop;
    assign o_exec       = (state == S_EXEC);
    assign o_rsp_valid  = (state == S_RESP) && (rsp_cred != '0);
    assign o_retire     = o_rsp_valid;
    assign o_cmd        = cmd_q;
    assign o_rsp        = rsp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  state <= o_pop ? S_EXEC : S_IDLE;
                S_EXEC:  state <= S_RESP;
                default: state <= o_rsp_valid ? S_IDLE : S_RESP;
            endcase
        end
    end

    // response credits, one spent per response
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_cred <= CRED_W'(`CSR_CREDITS);
        end else begin
            case ({i_rsp_credit, o_rsp_valid})
                2'b10:   rsp_cred <= rsp_cred + 1'b1;
                2'b01:   rsp_cred <= rsp_cred - 1'b1;
                default: rsp_cred <= rsp_cred;
            endcase
        end
    end

    // command and response payload
    always_ff @(posedge clk) begin
        if (o_pop) begin
            cmd_q          <= cmd_d;
            rsp_q.rd       <= is_csr ? inst.csr_view.rd : 5'd0;
            rsp_q.rd_we    <= is_csr;
            rsp_q.redirect <= is_ecall || is_mret;
        end
        if (o_exec) begin
            // old value, the update lands at the end of this cycle
            rsp_q.rd_val      <= i_rdata;
            rsp_q.redirect_pc <= (cmd_q.op == csr_pkg::CSR_OP_ECALL) ? i_mtvec : i_mepc;
        end
    end

endmodule

// ==== source/csr_counters.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_counters (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_retire,
    output logic [`CSR_XLEN-1:0] o_mcycle,
    output logic [`CSR_XLEN-1:0] o_minstret
);

    // free-running cycle count
    always_ff @(posedge clk) begin
        if (reset) begin
            o_mcycle <= '0;
        end else begin
            o_mcycle <= o_mcycle + 1'b1;
        end
    end

    // one tick per issued response
    always_ff @(posedge clk) begin
        if (reset) begin
            o_minstret <= '0;
        end else if (i_retire) begin
            o_minstret <= o_minstret + 1'b1;
        end
    end

endmodule

// ==== source/csr_regfile.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_exec,
    input  csr_pkg::csr_cmd_t    i_cmd,
    input  logic [`CSR_XLEN-1:0] i_mcycle,
    input  logic [`CSR_XLEN-1:0] i_minstret,
    output logic [`CSR_XLEN-1:0] o_rdata,
    output logic [`CSR_XLEN-1:0] o_mstatus,
    output logic [`CSR_XLEN-1:0] o_mtvec,
    output logic [`CSR_XLEN-1:0] o_mepc
);

    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] wval;

    // read mux, unknown addresses read zero
    always_comb begin
        case (i_cmd.addr)
            `CSR_A_MSTATUS:   o_rdata = mstatus;
            `CSR_A_MIE:       o_rdata = mie;
            `CSR_A_MTVEC:     o_rdata = mtvec;
            `CSR_A_MSCRATCH:  o_rdata = mscratch;
            `CSR_A_MEPC:      o_rdata = mepc;
            `CSR_A_MCAUSE:    o_rdata = mcause;
            `CSR_A_MTVAL:     o_rdata = mtval;
            `CSR_A_MCYCLE:    o_rdata = i_mcycle;
            `CSR_A_MINSTRET:  o_rdata = i_minstret;
            `CSR_A_MVENDORID: o_rdata = `CSR_MVENDORID_VAL;
            `CSR_A_MARCHID:   o_rdata = `CSR_MARCHID_VAL;
            default:          o_rdata = '0;
        endcase
    end

    // new value for the read-modify-write forms
    always_comb begin
        case (i_cmd.op)
            csr_pkg::CSR_OP_SET:   wval = o_rdata | i_cmd.wdata;
            csr_pkg::CSR_OP_CLEAR: wval = o_rdata & ~i_cmd.wdata;
            default:               wval = i_cmd.wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (i_exec) begin
            case (i_cmd.op)
                csr_pkg::CSR_OP_ECALL: begin
                    mepc    <= i_cmd.pc;
                    mcause  <= `CSR_CAUSE_ECALL;
                    mstatus <= mstatus | `CSR_MPP_MASK;
                end
                csr_pkg::CSR_OP_MRET: begin
                    mstatus <= mstatus & ~`CSR_MPP_MASK;
                end
                csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_OP_SET, csr_pkg::CSR_OP_CLEAR: begin
                    // counters and id registers drop out here
                    case (i_cmd.addr)
                        `CSR_A_MSTATUS:  mstatus  <= wval;
                        `CSR_A_MIE:      mie      <= wval;
                        `CSR_A_MTVEC:    mtvec    <= wval;
                        `CSR_A_MSCRATCH: mscratch <= wval;
                        `CSR_A_MEPC:     mepc     <= wval;
                        `CSR_A_MCAUSE:   mcause   <= wval;
                        `CSR_A_MTVAL:    mtval    <= wval;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign o_mstatus = mstatus;
    assign o_mtvec   = mtvec;
    assign o_mepc    = mepc;

endmodule

// ==== source/csr_unit_top.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_req_valid,
    input  csr_pkg::sys_req_t    i_req,
    output logic                 o_req_credit,
    input  logic                 i_rsp_credit,
    output logic                 o_rsp_valid,
    output csr_pkg::sys_rsp_t    o_rsp,
    output logic [`CSR_XLEN-1:0] o_mstatus,
    output logic [`CSR_XLEN-1:0] o_mtvec
);

    logic                 fifo_empty;
    logic                 fifo_pop;
    csr_pkg::sys_req_t    fifo_head;
    csr_pkg::csr_cmd_t    cmd;
    logic                 exec;
    logic                 retire;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcycle;
    logic [`CSR_XLEN-1:0] minstret;

    csr_req_fifo req_fifo0 (
        .clk     (clk),
        .reset   (reset),
        .i_push  (i_req_valid),
        .i_req   (i_req),
        .i_pop   (fifo_pop),
        .o_empty (fifo_empty),
        .o_head  (fifo_head)
    );

    csr_seq_fsm seq0 (
        .clk          (clk),
        .reset        (reset),
        .i_empty      (fifo_empty),
        .i_head       (fifo_head),
        .o_pop        (fifo_pop),
        .o_req_credit (o_req_credit),
        .o_cmd        (cmd),
        .o_exec       (exec),
        .i_rdata      (rdata),
        .i_mtvec      (o_mtvec),
        .i_mepc       (mepc),
        .o_retire     (retire),
        .i_rsp_credit (i_rsp_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp)
    );

    csr_counters counters0 (
        .clk        (clk),
        .reset      (reset),
        .i_retire   (retire),
        .o_mcycle   (mcycle),
        .o_minstret (minstret)
    );

    // trap vector and status also go out to the core
    csr_regfile regfile0 (
        .clk        (clk),
        .reset      (reset),
        .i_exec     (exec),
        .i_cmd      (cmd),
        .i_mcycle   (mcycle),
        .i_minstret (minstret),
        .o_rdata    (rdata),
        .o_mstatus  (o_mstatus),
        .o_mtvec    (o_mtvec),
        .o_mepc     (mepc)
    );

endmodule

// ==== dv/csr_unit_assert.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_assert (
    input logic clk,
    input logic reset,
    input logic i_req_valid,
    input logic i_req_credit,
    input logic i_rsp_credit,
    input logic i_rsp_valid
);

    int req_out;
    int rsp_cred;

    // requests sitting in the unit, one credit back per pop
    always_ff @(posedge clk) begin
        if (reset) begin
            req_out <= 0;
        end else begin
            req_out <= req_out + int'(i_req_valid) - int'(i_req_credit);
        end
    end

    // response credits as the sequencer should see them
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_cred <= `CSR_CREDITS;
        end else begin
            rsp_cred <= rsp_cred + int'(i_rsp_credit) - int'(i_rsp_valid);
        end
    end

    req_within_credits: assert property (@(posedge clk) disable iff (reset)
        req_out <= `CSR_CREDITS)
        else $error("more requests outstanding than credits");

    rsp_needs_credit: assert property (@(posedge clk) disable iff (reset)
        i_rsp_valid |-> rsp_cred > 0)
        else $error("response issued with no response credit left");

    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!i_rsp_valid && !i_req_credit))
        else $error("unit output active during reset");

endmodule

bind csr_unit_top csr_unit_assert assert0 (
    .clk          (clk),
    .reset        (reset),
    .i_req_valid  (i_req_valid),
    .i_req_credit (o_req_credit),
    .i_rsp_credit (i_rsp_credit),
    .i_rsp_valid  (o_rsp_valid)
);

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_tb;

    // one expected response plus what the core should see on o_mstatus and o_mtvec
    typedef struct packed {
        logic              mcycle_read;
        csr_pkg::sys_rsp_t rsp;
        logic [31:0]       mstatus;
        logic [31:0]       mtvec;
    } exp_t;

    localparam int CYC_PER_REQ = 16;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 i_req_valid = 1'b0;
    csr_pkg::sys_req_t    i_req = '0;
    logic                 o_req_credit;
    logic                 i_rsp_credit = 1'b0;
    logic                 o_rsp_valid;
    csr_pkg::sys_rsp_t    o_rsp;
    logic [`CSR_XLEN-1:0] o_mstatus;
    logic [`CSR_XLEN-1:0] o_mtvec;

    csr_pkg::sys_req_t req_q[$];
    exp_t              exp_q[$];
    logic [31:0]       gen_lfsr = 32'd25;
    logic [31:0]       cons_lfsr = 32'd25;
    logic [31:0]       last_mcycle = '0;
    logic [31:0]       m_mstatus = '0;
    logic [31:0]       m_mie = '0;
    logic [31:0]       m_mtvec = '0;
    logic [31:0]       m_mscratch = '0;
    logic [31:0]       m_mepc = '0;
    logic [31:0]       m_mcause = '0;
    logic [31:0]       m_mtval = '0;
    int                n_req = 0;
    int                n_total = 0;
    int                credits = 0;
    int                returned = 0;
    int                rcvd = 0;
    int                checks = 0;
    int                errors = 0;
    int                cycles = 0;
    int                limit = 0;
    int                owed = 0;
    int                gap = 0;

    csr_unit_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_credit (o_req_credit),
        .i_rsp_credit (i_rsp_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .o_mstatus    (o_mstatus),
        .o_mtvec      (o_mtvec)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n bits, one lfsr step per bit
    task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic logic [11:0] pick_addr(input logic [1:0] i);
        case (i)
            2'd0:    return `CSR_A_MSCRATCH;
            2'd1:    return `CSR_A_MTVEC;
            2'd2:    return `CSR_A_MIE;
            default: return `CSR_A_MTVAL;
        endcase
    endfunction

    // reference view of the csr space, minstret is the count of earlier responses
    function automatic logic [31:0] model_read(input logic [11:0] a);
        case (a)
            `CSR_A_MSTATUS:   return m_mstatus;
            `CSR_A_MIE:       return m_mie;
            `CSR_A_MTVEC:     return m_mtvec;
            `CSR_A_MSCRATCH:  return m_mscratch;
            `CSR_A_MEPC:      return m_mepc;
            `CSR_A_MCAUSE:    return m_mcause;
            `CSR_A_MTVAL:     return m_mtval;
            `CSR_A_MINSTRET:  return 32'(n_req);
            `CSR_A_MVENDORID: return 32'h0000_0a5c;
            `CSR_A_MARCHID:   return 32'h0000_0017;
            default:          return '0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] a, input logic [31:0] v);
        case (a)
            `CSR_A_MSTATUS:  m_mstatus  = v;
            `CSR_A_MIE:      m_mie      = v;
            `CSR_A_MTVEC:    m_mtvec    = v;
            `CSR_A_MSCRATCH: m_mscratch = v;
            `CSR_A_MEPC:     m_mepc     = v;
            `CSR_A_MCAUSE:   m_mcause   = v;
            `CSR_A_MTVAL:    m_mtval    = v;
            default: ;
        endcase
    endtask

    task automatic queue_req(input csr_pkg::sys_req_t r, input exp_t e);
        req_q.push_back(r);
        exp_q.push_back(e);
        n_req++;
    endtask

    task automatic add_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] field);
        csr_pkg::sys_req_t r;
        exp_t              e;
        logic [31:0]       rnd;
        logic [31:0]       old;
        logic [31:0]       src;
        r = '0;
        e = '0;
        draw(gen_lfsr, 5, rnd);
        r.inst.csr_view.csr_addr = addr;
        r.inst.csr_view.rs1_uimm = field;
        r.inst.csr_view.funct3   = f3;
        r.inst.csr_view.rd       = rnd[4:0];
        r.inst.csr_view.opcode   = 7'b1110011;
        draw(gen_lfsr, 32, rnd);
        r.rs1_val = rnd;
        old = model_read(addr);
        src = f3[2] ? {27'd0, field} : r.rs1_val;
        e.mcycle_read = (addr == `CSR_A_MCYCLE);
        e.rsp.rd_val  = old;
        e.rsp.rd      = r.inst.csr_view.rd;
        e.rsp.rd_we   = 1'b1;
        // set and clear with a zero source only read
        if (f3[1:0] == 2'b01) begin
            model_write(addr, src);
        end else if (f3[1:0] == 2'b10 && field != 5'd0) begin
            model_write(addr, old | src);
        end else if (f3[1:0] == 2'b11 && field != 5'd0) begin
            model_write(addr, old & ~src);
        end
        e.mstatus = m_mstatus;
        e.mtvec   = m_mtvec;
        queue_req(r, e);
    endtask

    task automatic add_trap(input logic is_mret);
        csr_pkg::sys_req_t r;
        exp_t              e;
        logic [31:0]       rnd;
        r = '0;
        e = '0;
        r.inst.priv_view.opcode = 7'b1110011;
        if (is_mret) begin
            r.inst.priv_view.funct7 = 7'b0011000;
            r.inst.priv_view.rs2    = 5'd2;
        end
        draw(gen_lfsr, 30, rnd);
        r.pc = {rnd[29:0], 2'b00};
        e.rsp.redirect = 1'b1;
        if (is_mret) begin
            e.rsp.redirect_pc = m_mepc;
            m_mstatus = m_mstatus & ~32'h0000_1800;
        end else begin
            e.rsp.redirect_pc = m_mtvec;
            m_mepc    = r.pc;
            m_mcause  = 32'd11;
            m_mstatus = m_mstatus | 32'h0000_1800;
        end
        e.mstatus = m_mstatus;
        e.mtvec   = m_mtvec;
        queue_req(r, e);
    endtask

    task automatic build_tests();
        logic [31:0] rnd;
        // every csr form on scratch, vector and enable
        for (int a = 0; a < 3; a++) begin
            for (int f = 1; f < 8; f++) begin
                if (f != 4) begin
                    draw(gen_lfsr, 5, rnd);
                    add_csr(3'(f), pick_addr(2'(a)), rnd[4:0] | 5'd1);
                end
            end
            add_csr(3'd2, pick_addr(2'(a)), 5'd0);
            add_csr(3'd3, pick_addr(2'(a)), 5'd0);
            add_csr(3'd6, pick_addr(2'(a)), 5'd0);
            add_csr(3'd7, pick_addr(2'(a)), 5'd0);
        end
        // trap entry, then return
        add_trap(1'b0);
        add_csr(3'd2, `CSR_A_MEPC, 5'd0);
        add_csr(3'd2, `CSR_A_MCAUSE, 5'd0);
        add_csr(3'd2, `CSR_A_MSTATUS, 5'd0);
        add_trap(1'b1);
        add_csr(3'd2, `CSR_A_MSTATUS, 5'd0);
        // id registers hold, unknown address reads zero
        add_csr(3'd1, `CSR_A_MVENDORID, 5'd3);
        add_csr(3'd2, `CSR_A_MVENDORID, 5'd0);
        add_csr(3'd5, `CSR_A_MARCHID, 5'd9);
        add_csr(3'd2, `CSR_A_MARCHID, 5'd0);
        add_csr(3'd1, 12'h7c0, 5'd4);
        add_csr(3'd2, 12'h7c0, 5'd0);
        add_csr(3'd2, `CSR_A_MINSTRET, 5'd0);
        add_csr(3'd2, `CSR_A_MCYCLE, 5'd0);
        add_csr(3'd2, `CSR_A_MINSTRET, 5'd0);
        add_csr(3'd2, `CSR_A_MCYCLE, 5'd0);
        // random mix, counters read now and then
        for (int i = 0; i < 24; i++) begin
            draw(gen_lfsr, 12, rnd);
            if (rnd[11:10] == 2'b11) begin
                add_csr(3'd2, rnd[9] ? `CSR_A_MCYCLE : `CSR_A_MINSTRET, 5'd0);
            end else begin
                add_csr({rnd[9], (rnd[8:7] == 2'b00) ? 2'b01 : rnd[8:7]},
                        pick_addr(rnd[6:5]), rnd[4:0]);
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] %s got %h expected %h", name, got, exp);
    endtask

    task automatic check_rsp(input csr_pkg::sys_rsp_t got, input logic [31:0] mst,
                             input logic [31:0] mtv);
        exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("response arrived with no request outstanding");
        end else begin
            e = exp_q.pop_front();
            rcvd++;
            checks++;
            assert (got.rd_we == e.rsp.rd_we)
                else report_mismatch("rd_we", 32'(got.rd_we), 32'(e.rsp.rd_we));
            assert (got.rd == e.rsp.rd)
                else report_mismatch("rd", 32'(got.rd), 32'(e.rsp.rd));
            assert (got.redirect == e.rsp.redirect)
                else report_mismatch("redirect", 32'(got.redirect), 32'(e.rsp.redirect));
            if (e.rsp.redirect) begin
                assert (got.redirect_pc == e.rsp.redirect_pc)
                    else report_mismatch("redirect_pc", got.redirect_pc, e.rsp.redirect_pc);
            end
            if (e.mcycle_read) begin
                assert (got.rd_val > last_mcycle)
                    else report_mismatch("mcycle rd_val vs previous", got.rd_val, last_mcycle);
                last_mcycle = got.rd_val;
            end else if (e.rsp.rd_we) begin
                assert (got.rd_val == e.rsp.rd_val)
                    else report_mismatch("rd_val", got.rd_val, e.rsp.rd_val);
            end
            assert (mst == e.mstatus)
                else report_mismatch("o_mstatus", mst, e.mstatus);
            assert (mtv == e.mtvec)
                else report_mismatch("o_mtvec", mtv, e.mtvec);
        end
    endtask

    // request driver, spends one credit per valid
    always @(posedge clk) begin
        if (reset) begin
            i_req_valid <= 1'b0;
            credits = `CSR_CREDITS;
        end else begin
            if (o_req_credit) begin
                credits++;
                returned++;
            end
            if (credits > 0 && req_q.size() > 0) begin
                i_req_valid <= 1'b1;
                i_req       <= req_q.pop_front();
                credits--;
            end else begin
                i_req_valid <= 1'b0;
            end
        end
    end

    // consumer, hands credits back after random gaps
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (reset) begin
            i_rsp_credit <= 1'b0;
            owed = 0;
            gap  = 0;
        end else begin
            if (o_rsp_valid) begin
                check_rsp(o_rsp, o_mstatus, o_mtvec);
                owed++;
            end
            if (owed > 0 && gap == 0) begin
                i_rsp_credit <= 1'b1;
                owed--;
                draw(cons_lfsr, 3, rnd);
                gap = int'(rnd[2:0]);
            end else begin
                i_rsp_credit <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    end

    initial begin
        build_tests();
        n_total = n_req;
        limit   = n_total * CYC_PER_REQ + 50;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (rcvd < n_total && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (4) @(posedge clk);
        if (rcvd < n_total) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, rcvd,
                     n_total);
        end
        assert (returned == n_total)
            else report_mismatch("o_req_credit count", 32'(returned), 32'(n_total));
        $display("errors %0d, checks %0d, responses %0d of %0d", errors, checks, rcvd, n_total);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/csr_pkg.sv
source/csr_req_fifo.sv
source/csr_seq_fsm.sv
source/csr_counters.sv
source/csr_regfile.sv
source/csr_unit_top.sv
dv/csr_unit_assert.sv
dv/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := csr_unit_tb
FILELIST   := build.f
FLAGS      := --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended early"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
